/* vga_pkg.sv */
// VGA video timing definitions
// 640x480 at 60 Hz on a 25 MHz pixel clock, plus the sync bundle

package vga_pkg;

    // horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = 800;   // sum of the four above

    // vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = 525;

    // all three are active low
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic blank_n;
    } vga_sync_t;

    // level seen on the pins while nothing is displayed
    localparam vga_sync_t SYNC_IDLE = '{
        hsync_n: 1'b1,
        vsync_n: 1'b1,
        blank_n: 1'b0
    };

endpackage

/* pixel_pkg.sv */
// Pixel formats and frame-buffer geometry
// RGB565 storage, RGB888 output, write bundle and display mode

package pixel_pkg;

    localparam int FB_WIDTH  = 320;
    localparam int FB_HEIGHT = 240;
    localparam int FB_WORDS  = FB_WIDTH * FB_HEIGHT;   // 76800 pixels
    localparam int FB_ADDR_W = 17;

    // stored format, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // output format to the DAC
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    // one pixel write, strobed by we
    typedef struct packed {
        logic                 we;
        logic [FB_ADDR_W-1:0] addr;
        rgb565_t              data;
    } fb_write_t;

    typedef enum logic {
        MODE_COLOR = 1'b0,
        MODE_GRAY  = 1'b1
    } display_mode_t;

endpackage

/* vga_timing.sv */
`timescale 1ns/1ps
// VGA timing generator for 640x480
// counts pixels and lines, decodes syncs and forms the 2x2 scaled read address

module vga_timing (
    input  logic                            clk_25_vga,
    input  logic                            rst,
    output vga_pkg::vga_sync_t              raw_sync,
    output logic                            active,
    output logic [pixel_pkg::FB_ADDR_W-1:0] rd_addr
);

    localparam int AW       = pixel_pkg::FB_ADDR_W;
    localparam int HS_START = vga_pkg::H_ACTIVE + vga_pkg::H_FRONT;   // 656
    localparam int HS_END   = HS_START + vga_pkg::H_SYNC;             // 752, exclusive
    localparam int VS_START = vga_pkg::V_ACTIVE + vga_pkg::V_FRONT;   // 490
    localparam int VS_END   = VS_START + vga_pkg::V_SYNC;             // 492, exclusive

    logic [9:0]    h_count;
    logic [9:0]    v_count;
    logic          h_last;
    logic          v_last;
    logic [AW-1:0] row_base;   // address of first pixel in stored row

    assign h_last = (h_count == 10'(vga_pkg::H_TOTAL - 1));
    assign v_last = (v_count == 10'(vga_pkg::V_TOTAL - 1));

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 10'd1;   // wrap at end of frame
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    // each stored row is shown on two display lines, so the base
    // only moves after the odd line of each pair
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            row_base <= '0;
        end else if (h_last) begin
            if (v_last) begin
                row_base <= '0;
            end else if (v_count[0] && (v_count < 10'(vga_pkg::V_ACTIVE))) begin
                row_base <= row_base + AW'(pixel_pkg::FB_WIDTH);
            end
        end
    end

    assign active = (h_count < 10'(vga_pkg::H_ACTIVE)) &&
                    (v_count < 10'(vga_pkg::V_ACTIVE));

    always_comb begin
        raw_sync.hsync_n = !((h_count >= 10'(HS_START)) && (h_count < 10'(HS_END)));
        raw_sync.vsync_n = !((v_count >= 10'(VS_START)) && (v_count < 10'(VS_END)));
        raw_sync.blank_n = active;
    end

    // h_count/2 picks the stored column
    assign rd_addr = active ? row_base + AW'(h_count[9:1]) : '0;

    // row base must land exactly on the buffer size at the last active line
    a_rd_addr_range: assert property (
        @(posedge clk_25_vga) disable iff (rst)
        active |-> (rd_addr < AW'(pixel_pkg::FB_WORDS))
    ) else $error("read address %0d past frame buffer", rd_addr);

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ps
// Two-bank frame buffer for 320x240 RGB565
// write port and registered read port, bank 1 addressed with an offset

module frame_buffer #(
    parameter int BANK0_WORDS = 32768
) (
    input  logic                            clk_25_vga,
    input  logic                            rst,
    input  pixel_pkg::fb_write_t            fb_wr,
    input  logic [pixel_pkg::FB_ADDR_W-1:0] rd_addr,
    output pixel_pkg::rgb565_t              rd_data
);

    localparam int AW          = pixel_pkg::FB_ADDR_W;
    localparam int BANK1_WORDS = pixel_pkg::FB_WORDS - BANK0_WORDS;   // 44032 by default
    localparam int B0_AW       = $clog2(BANK0_WORDS);
    localparam int B1_AW       = $clog2(BANK1_WORDS);

    pixel_pkg::rgb565_t bank0_mem [BANK0_WORDS];
    pixel_pkg::rgb565_t bank1_mem [BANK1_WORDS];

    logic [AW-1:0]      wr_off;
    logic [AW-1:0]      rd_off;
    logic               bank0_we;
    logic               bank1_we;
    logic               rd_bank1;
    logic               rd_bank1_q;   // bank choice aligned with read data
    logic [B0_AW-1:0]   rd_idx0;
    logic [B1_AW-1:0]   rd_idx1;
    pixel_pkg::rgb565_t bank0_q;
    pixel_pkg::rgb565_t bank1_q;

    // write routing, out of range addresses hit neither bank
    assign wr_off   = fb_wr.addr - AW'(BANK0_WORDS);
    assign bank0_we = fb_wr.we && (fb_wr.addr < AW'(BANK0_WORDS));
    assign bank1_we = fb_wr.we && (fb_wr.addr >= AW'(BANK0_WORDS)) &&
                      (fb_wr.addr < AW'(pixel_pkg::FB_WORDS));

    always_ff @(posedge clk_25_vga) begin
        if (bank0_we) begin
            bank0_mem[fb_wr.addr[B0_AW-1:0]] <= fb_wr.data;
        end
        if (bank1_we) begin
            bank1_mem[wr_off[B1_AW-1:0]] <= fb_wr.data;
        end
    end

    assign rd_bank1 = (rd_addr >= AW'(BANK0_WORDS));
    assign rd_off   = rd_addr - AW'(BANK0_WORDS);
    assign rd_idx0  = rd_bank1 ? '0 : rd_addr[B0_AW-1:0];   // idle bank parks at 0
    assign rd_idx1  = rd_bank1 ? rd_off[B1_AW-1:0] : '0;

    always_ff @(posedge clk_25_vga) begin
        bank0_q <= bank0_mem[rd_idx0];
        bank1_q <= bank1_mem[rd_idx1];
    end

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            rd_bank1_q <= 1'b0;
        end else begin
            rd_bank1_q <= rd_bank1;
        end
    end

    assign rd_data = rd_bank1_q ? bank1_q : bank0_q;

    a_one_bank: assert property (
        @(posedge clk_25_vga) disable iff (rst)
        !(bank0_we && bank1_we)
    ) else $error("write to address %0d enabled both banks", fb_wr.addr);

endmodule

/* pixel_pipeline.sv */
`timescale 1ns/1ps
// Pixel output pipeline
// RGB565 to RGB888, optional grayscale, blanking and matching sync delay

module pixel_pipeline (
    input  logic               clk_25_vga,
    input  logic               rst,
    input  logic               sw_grayscale,
    input  vga_pkg::vga_sync_t raw_sync,
    input  logic               active,
    input  pixel_pkg::rgb565_t rd_data,
    output vga_pkg::vga_sync_t vga_out,
    output pixel_pkg::rgb888_t vga_rgb
);

    vga_pkg::vga_sync_t       sync_d0;       // lines up with rd_data
    vga_pkg::vga_sync_t       sync_d1;
    logic                     active_d0;
    logic                     active_d1;
    pixel_pkg::rgb888_t       rgb_exp;
    logic [15:0]              gray_sum;
    pixel_pkg::rgb888_t       rgb_s1;
    logic [15:0]              gray_sum_s1;
    logic [7:0]               gray_s1;
    pixel_pkg::display_mode_t mode_q;

    // low bits padded with ones so full scale reaches 0xff
    always_comb begin
        rgb_exp.red   = {rd_data.red, 3'b111};
        rgb_exp.green = {rd_data.green, 2'b11};
        rgb_exp.blue  = {rd_data.blue, 3'b111};
    end

    // weights sum to 252, max result 64260 fits 16 bits
    assign gray_sum = 16'(rgb_exp.red) * 16'd76 +
                      16'(rgb_exp.green) * 16'd150 +
                      16'(rgb_exp.blue) * 16'd26;

    assign gray_s1 = gray_sum_s1[15:8];

    // control path, sync and active follow the data
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            sync_d0   <= vga_pkg::SYNC_IDLE;
            sync_d1   <= vga_pkg::SYNC_IDLE;
            active_d0 <= 1'b0;
            active_d1 <= 1'b0;
            mode_q    <= pixel_pkg::MODE_COLOR;
        end else begin
            sync_d0   <= raw_sync;
            sync_d1   <= sync_d0;
            active_d0 <= active;
            active_d1 <= active_d0;
            mode_q    <= sw_grayscale ? pixel_pkg::MODE_GRAY : pixel_pkg::MODE_COLOR;
        end
    end

    // stage 1 data
    always_ff @(posedge clk_25_vga) begin
        rgb_s1      <= rgb_exp;
        gray_sum_s1 <= gray_sum;
    end

    // stage 2, mode select and blanking
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            vga_out <= vga_pkg::SYNC_IDLE;
            vga_rgb <= '0;
        end else begin
            vga_out <= sync_d1;
            if (!active_d1) begin
                vga_rgb <= '0;
            end else begin
                case (mode_q)
                    pixel_pkg::MODE_GRAY:  vga_rgb <= '{red: gray_s1, green: gray_s1,
                                                        blue: gray_s1};
                    default:               vga_rgb <= rgb_s1;
                endcase
            end
        end
    end

    // blank_n and active take separate paths through the pipe
    a_blank_black: assert property (
        @(posedge clk_25_vga) disable iff (rst)
        !vga_out.blank_n |-> (vga_rgb == '0)
    ) else $error("colour 0x%06h driven during blanking", vga_rgb);

endmodule

/* cam_display_top.sv */
`timescale 1ns/1ps
// Camera display top level
// frame buffer read out through VGA timing and the pixel pipeline

module cam_display_top #(
    parameter int BANK0_WORDS = 32768
) (
    input  logic                 clk_25_vga,
    input  logic                 rst,
    input  pixel_pkg::fb_write_t fb_wr,
    input  logic                 sw_grayscale,
    output vga_pkg::vga_sync_t   vga_out,
    output pixel_pkg::rgb888_t   vga_rgb
);

    vga_pkg::vga_sync_t              raw_sync;   // undelayed, 3 cycles ahead of pins
    logic                            active;
    logic [pixel_pkg::FB_ADDR_W-1:0] rd_addr;
    pixel_pkg::rgb565_t              rd_data;

    vga_timing timing_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .raw_sync   (raw_sync),
        .active     (active),
        .rd_addr    (rd_addr)
    );

    frame_buffer #(
        .BANK0_WORDS (BANK0_WORDS)
    ) fb_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .fb_wr      (fb_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    pixel_pipeline pipe_i (
        .clk_25_vga   (clk_25_vga),
        .rst          (rst),
        .sw_grayscale (sw_grayscale),
        .raw_sync     (raw_sync),
        .active       (active),
        .rd_data      (rd_data),
        .vga_out      (vga_out),
        .vga_rgb      (vga_rgb)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps
// Testbench clock and reset source
// free running pixel clock, reset held for the first rising edges

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_25_vga,
    output logic rst
);

    initial begin
        clk_25_vga = 1'b0;
        forever #(PERIOD_NS / 2) clk_25_vga = ~clk_25_vga;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_25_vga);
        #1 rst = 1'b0;   // released with the other inputs
    end

endmodule

/* cam_display_tb.sv */
`timescale 1ns/1ps
// Testbench for the camera display top level
// fills the frame buffer, then checks one colour and one gray frame with assertions

module cam_display_tb;

    localparam int FB_PIXELS    = 76800;
    localparam int LINE_CYCLES  = 800;
    localparam int FRAME_CYCLES = 420000;   // 525 lines
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam logic [15:0] NEW_FIRST = 16'hf81f;
    localparam logic [15:0] NEW_LAST  = 16'h07e0;
    localparam vga_pkg::vga_sync_t IDLE_SYNC = '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0};

    logic                 clk_25_vga;
    logic                 rst;
    pixel_pkg::fb_write_t fb_wr;
    logic                 sw_grayscale;
    vga_pkg::vga_sync_t   vga_out;
    pixel_pkg::rgb888_t   vga_rgb;

    logic [15:0]        ref_mem [0:FB_PIXELS-1];   // expected buffer contents
    logic [15:0]        lfsr_word;
    logic               check_on;
    logic               gray_check;
    logic               live_done;
    logic               rst_q = 1'b0;
    vga_pkg::vga_sync_t prev_sync;
    int                 col_q;
    int                 line_cnt;
    logic               frame_seen;
    int                 hs_period;
    int                 hs_low;
    logic               hs_seen;
    int                 vs_period;
    int                 vs_low;
    logic               vs_seen;
    logic               hs_fell;
    logic               hs_rose;
    logic               vs_fell;
    logic               vs_rose;
    logic               blank_fell;
    logic [16:0]        exp_addr;
    pixel_pkg::rgb888_t exp_rgb;
    pixel_pkg::rgb888_t live_exp;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst)
    );

    cam_display_top #(.BANK0_WORDS(32768)) dut_i (
        .clk_25_vga   (clk_25_vga),
        .rst          (rst),
        .fb_wr        (fb_wr),
        .sw_grayscale (sw_grayscale),
        .vga_out      (vga_out),
        .vga_rgb      (vga_rgb)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] make_lfsr_word(logic [31:0] seed);
        logic [31:0] s;
        logic [15:0] w;
        s = seed;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            s = lfsr_next(s);
            w = {w[14:0], s[0]};   // one step per bit
        end
        return w;
    endfunction

    function automatic logic [15:0] pattern_word(logic [16:0] addr);
        logic [31:0] prod;
        prod = 32'(addr) * 32'd40503;
        return prod[15:0] ^ lfsr_word;
    endfunction

    // RGB565 to RGB888 with ones in the low bits, optionally gray
    function automatic pixel_pkg::rgb888_t shade(logic [15:0] px, logic gray);
        pixel_pkg::rgb888_t c;
        int                 sum;
        c.red   = {px[15:11], 3'b111};
        c.green = {px[10:5], 2'b11};
        c.blue  = {px[4:0], 3'b111};
        sum = 76 * int'(c.red) + 150 * int'(c.green) + 26 * int'(c.blue);
        if (gray) begin
            c.red   = 8'(sum >> 8);
            c.green = 8'(sum >> 8);
            c.blue  = 8'(sum >> 8);
        end
        return c;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_value(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        abort_run();
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic wait_reset_release();
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < 16) begin
            @(posedge clk_25_vga);
            done = !rst;
            n++;
        end
        if (!done) timeout_fail("reset release");
        #1;
    endtask

    task automatic wait_vsync_fall();
        int   n;
        logic prev;
        logic found;
        n = 0;
        found = 1'b0;
        while (!found && n < WAIT_LIMIT) begin
            prev = vga_out.vsync_n;
            @(posedge clk_25_vga);
            #1;
            found = prev && !vga_out.vsync_n;
            n++;
        end
        if (!found) timeout_fail("falling edge of vsync_n");
    endtask

    task automatic wait_for_line(int target);
        int n;
        n = 0;
        while (line_cnt != target && n < WAIT_LIMIT) begin
            @(posedge clk_25_vga);
            #1;
            n++;
        end
        if (line_cnt != target) timeout_fail("display line");
    endtask

    // one write strobe, mirrored in the reference memory
    task automatic store_pixel(logic [16:0] addr, logic [15:0] data);
        fb_wr.we   = 1'b1;
        fb_wr.addr = addr;
        fb_wr.data = data;
        ref_mem[addr] = data;
        @(posedge clk_25_vga);
        #1;
    endtask

    assign hs_fell    = prev_sync.hsync_n && !vga_out.hsync_n;
    assign hs_rose    = !prev_sync.hsync_n && vga_out.hsync_n;
    assign vs_fell    = prev_sync.vsync_n && !vga_out.vsync_n;
    assign vs_rose    = !prev_sync.vsync_n && vga_out.vsync_n;
    assign blank_fell = prev_sync.blank_n && !vga_out.blank_n;

    // own column and line, taken from the output syncs
    always @(posedge clk_25_vga) begin
        rst_q <= rst;
        if (rst) begin
            prev_sync  <= IDLE_SYNC;
            col_q      <= 0;
            line_cnt   <= 0;
            frame_seen <= 1'b0;
            hs_period  <= 0;
            hs_low     <= 0;
            hs_seen    <= 1'b0;
            vs_period  <= 0;
            vs_low     <= 0;
            vs_seen    <= 1'b0;
        end else begin
            prev_sync <= vga_out;
            col_q     <= vga_out.blank_n ? col_q + 1 : 0;
            if (vs_fell) begin
                line_cnt   <= 0;
                frame_seen <= 1'b1;
            end else if (vga_out.blank_n && col_q == 639) begin
                line_cnt <= line_cnt + 1;   // line ends after 640 pixels
            end
            hs_period <= hs_fell ? 1 : hs_period + 1;
            hs_low    <= !vga_out.hsync_n ? hs_low + 1 : 0;
            hs_seen   <= hs_seen || hs_fell;
            vs_period <= vs_fell ? 1 : vs_period + 1;
            vs_low    <= !vga_out.vsync_n ? vs_low + 1 : 0;
            vs_seen   <= vs_seen || vs_fell;
        end
    end

    always_comb begin
        if (line_cnt < 480 && col_q < 640) begin
            exp_addr = 17'((line_cnt / 2) * 320 + col_q / 2);
        end else begin
            exp_addr = '0;
        end
        exp_rgb  = shade(ref_mem[exp_addr], gray_check);
        live_exp = shade((col_q == 0) ? NEW_FIRST : NEW_LAST, gray_check);
    end

    a_reset_idle: assert property (@(posedge clk_25_vga)
        rst_q |-> (vga_out == IDLE_SYNC && vga_rgb == '0)
    ) else fail_value("reset_idle", 32'({IDLE_SYNC, 24'h0}),
                      32'({$sampled(vga_out), $sampled(vga_rgb)}));

    a_hsync_period: assert property (@(posedge clk_25_vga) disable iff (rst)
        (hs_fell && hs_seen) |-> (hs_period == LINE_CYCLES)
    ) else fail_value("sync_timing", LINE_CYCLES, $sampled(hs_period));

    a_hsync_width: assert property (@(posedge clk_25_vga) disable iff (rst)
        hs_rose |-> (hs_low == 96)
    ) else fail_value("sync_timing", 96, $sampled(hs_low));

    a_vsync_width: assert property (@(posedge clk_25_vga) disable iff (rst)
        vs_rose |-> (vs_low == 1600)   // two whole lines
    ) else fail_value("sync_timing", 1600, $sampled(vs_low));

    a_vsync_period: assert property (@(posedge clk_25_vga) disable iff (rst)
        (vs_fell && vs_seen) |-> (vs_period == FRAME_CYCLES)
    ) else fail_value("sync_timing", FRAME_CYCLES, $sampled(vs_period));

    a_line_count: assert property (@(posedge clk_25_vga) disable iff (rst)
        (vs_fell && frame_seen) |-> (line_cnt == 480)
    ) else fail_value("sync_timing", 480, $sampled(line_cnt));

    a_line_width: assert property (@(posedge clk_25_vga) disable iff (rst)
        blank_fell |-> (col_q == 640)
    ) else fail_value("sync_timing", 640, $sampled(col_q));

    a_color_pixels: assert property (@(posedge clk_25_vga) disable iff (rst)
        (check_on && !gray_check && vga_out.blank_n) |-> (vga_rgb == exp_rgb)
    ) else fail_value("color_pixels", 32'($sampled(exp_rgb)), 32'($sampled(vga_rgb)));

    a_gray_pixels: assert property (@(posedge clk_25_vga) disable iff (rst)
        (check_on && gray_check && vga_out.blank_n) |-> (vga_rgb == exp_rgb)
    ) else fail_value("gray_pixels", 32'($sampled(exp_rgb)), 32'($sampled(vga_rgb)));

    a_blanking: assert property (@(posedge clk_25_vga) disable iff (rst)
        !vga_out.blank_n |-> (vga_rgb == '0)
    ) else fail_value("blanking", 0, 32'($sampled(vga_rgb)));

    a_live_write: assert property (@(posedge clk_25_vga) disable iff (rst)
        (live_done && vga_out.blank_n &&
         ((col_q == 0 && line_cnt == 0) || (col_q == 639 && line_cnt == 479)))
        |-> (vga_rgb == live_exp)
    ) else fail_value("live_write", 32'($sampled(live_exp)), 32'($sampled(vga_rgb)));

    initial begin
        fb_wr        = '0;
        sw_grayscale = 1'b0;
        check_on     = 1'b0;
        gray_check   = 1'b0;
        live_done    = 1'b0;
        lfsr_word    = make_lfsr_word(32'hf9a2);
        wait_reset_release();
        for (int i = 0; i < FB_PIXELS; i++) begin
            store_pixel(17'(i), pattern_word(17'(i)));
        end
        fb_wr.we = 1'b0;
        wait_vsync_fall();
        check_on = 1'b1;   // colour frame starts after the back porch
        wait_for_line(240);
        store_pixel(17'd0, NEW_FIRST);   // mid frame, row 0 already shown
        store_pixel(17'(FB_PIXELS - 1), NEW_LAST);
        fb_wr.we = 1'b0;
        wait_vsync_fall();
        sw_grayscale = 1'b1;
        gray_check   = 1'b1;
        live_done    = 1'b1;
        wait_vsync_fall();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* sources.f */
vga_pkg.sv
pixel_pkg.sv
vga_timing.sv
frame_buffer.sv
pixel_pipeline.sv
cam_display_top.sv
tb_clock_gen.sv
cam_display_tb.sv

/* Makefile */
TOP = cam_display_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
